// File: tb.f
common/lsu_pkg.sv
common/cache_pkg.sv
lsu/lsu_am.sv
lsu/lsu_dt.sv
lsu/lsu_dw.sv
lsu/lsu_dc.sv
lsu/lsu_replay_queue.sv
mhq/mhq_fsm.sv
verilog/lsu_top.sv
sim/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the load pipeline testbench with Verilator, run it and scan the log
rm -f sim.log &&
verilator --binary --timing -Wno-fatal --top-module lsu_tb -f tb.f -o lsu_sim &&
{ ./obj_dir/lsu_sim 2>&1 | tee sim.log; true; } &&
grep -q "ALL CHECKS PASSED" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: sim/lsu_tb.sv
// Self-checking testbench for the load pipeline with a memory model and a reference model
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int NUM_LOADS       = 400;
    localparam int MAX_INFLIGHT    = 4;
    localparam int NUM_LINES       = 64;
    // Misses, replays and memory latency all fit well inside 40 cycles per load
    localparam int WATCHDOG_CYCLES = NUM_LOADS * 40 + 500;

    logic        clk = 1'b0;
    logic        i_rst_n;
    logic        i_flush;
    logic        i_ld_valid;
    lsu_func_e   i_ld_func;
    logic [3:0]  i_ld_tag;
    logic [15:0] i_ld_base;
    logic [15:0] i_ld_offset;
    logic        o_stall;
    logic        o_resp_valid;
    lsu_resp_t   o_resp;
    logic        o_mem_req;
    logic [13:0] o_mem_line;
    logic        i_mem_valid;
    logic [31:0] i_mem_data;

    // Reference state
    logic [31:0] mem_word [NUM_LINES];
    logic [NUM_LINES-1:0] line_issued;
    bit          pending [16];
    lsu_func_e   pend_func [16];
    logic [15:0] pend_addr [16];
    int          pending_count;
    int          issued;
    int          answered;
    int          flushed;
    int          held_offers;

    // Load on offer, held until the DUT takes it
    logic        offer_valid;
    lsu_func_e   offer_func;
    logic [3:0]  offer_tag;
    logic [15:0] offer_addr;
    logic [15:0] offer_base;
    logic [15:0] offer_offset;

    // Memory model
    logic        mem_busy;
    int          mem_wait;
    logic [5:0]  mem_line;
    logic        recent_valid;
    logic [5:0]  recent_line;

    always #4 clk = ~clk;

    lsu_top dut_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_ld_valid(i_ld_valid), .i_ld_func(i_ld_func), .i_ld_tag(i_ld_tag),
        .i_ld_base(i_ld_base), .i_ld_offset(i_ld_offset), .o_stall(o_stall),
        .o_resp_valid(o_resp_valid), .o_resp(o_resp),
        .o_mem_req(o_mem_req), .o_mem_line(o_mem_line),
        .i_mem_valid(i_mem_valid), .i_mem_data(i_mem_data)
    );

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Picks the addressed byte or halfword and extends it as the opcode asks
    function automatic logic [31:0] expected_data(input lsu_func_e func,
                                                  input logic [31:0] word,
                                                  input logic [1:0] boff);
        logic [15:0] half;
        logic [7:0]  byte_val;
        half = boff[1] ? word[31:16] : word[15:0];
        case (boff)
            2'd0:    byte_val = word[7:0];
            2'd1:    byte_val = word[15:8];
            2'd2:    byte_val = word[23:16];
            default: byte_val = word[31:24];
        endcase
        case (func)
            LSU_LH:  return {{16{half[15]}}, half};
            LSU_HU:  return {16'd0, half};
            LSU_LB:  return {{24{byte_val[7]}}, byte_val};
            LSU_LBU: return {24'd0, byte_val};
            default: return word;
        endcase
    endfunction

    function automatic logic [3:0] free_tag();
        logic [3:0] t;
        t = 4'($urandom);
        for (int i = 0; i < 16; i++) begin
            if (!pending[t]) begin
                return t;
            end
            t = t + 4'd1;
        end
        return t;
    endfunction

    task automatic build_offer();
        logic [5:0] line;
        logic [1:0] boff;
        offer_func = lsu_func_e'($urandom_range(0, 4));
        case (offer_func)
            LSU_LW:         boff = 2'd0;
            LSU_LH, LSU_HU: boff = {1'($urandom_range(0, 1)), 1'b0};
            default:        boff = 2'($urandom_range(0, 3));
        endcase
        // Half the loads go back to the line memory returned last
        if (recent_valid && $urandom_range(0, 1) == 1) begin
            line = recent_line;
        end else begin
            line = 6'($urandom_range(0, NUM_LINES - 1));
        end
        offer_tag    = free_tag();
        offer_addr   = {8'd0, line, boff};
        offer_offset = 16'($urandom);
        offer_base   = offer_addr - offer_offset;
        offer_valid  = 1'b1;
    endtask

    task automatic check_response();
        logic [3:0] tag;
        if (o_resp_valid) begin
            tag = o_resp.tag;
            if ($isunknown(o_resp.tag)) begin
                report_error("Response carries a tag with unknown bits");
            end else if (!pending[tag]) begin
                report_error($sformatf("Response for tag %0d, which has no load in flight", tag));
            end else begin
                check_eq("o_resp.data",
                         expected_data(pend_func[tag], mem_word[pend_addr[tag][7:2]],
                                       pend_addr[tag][1:0]),
                         o_resp.data);
                pending[tag]  = 1'b0;
                pending_count = pending_count - 1;
                answered      = answered + 1;
            end
        end
    endtask

    task automatic serve_memory();
        i_mem_valid = 1'b0;
        if (o_mem_req) begin
            if (mem_busy) begin
                report_error("Memory request issued while the previous read is still open");
            end else if (o_mem_line[13:6] != 8'd0 || !line_issued[o_mem_line[5:0]]) begin
                report_error("Memory request for a line that no load has used");
            end else begin
                mem_busy = 1'b1;
                mem_line = o_mem_line[5:0];
                mem_wait = $urandom_range(1, 12);
            end
        end else if (mem_busy) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                i_mem_valid  = 1'b1;
                i_mem_data   = mem_word[mem_line];
                mem_busy     = 1'b0;
                recent_line  = mem_line;
                recent_valid = 1'b1;
            end
        end
    endtask

    task automatic drive_loads();
        i_flush    = 1'b0;
        i_ld_valid = 1'b0;
        if (pending_count != 0 && $urandom_range(0, 99) < 2) begin
            // Everything in flight is dropped on the coming edge
            i_flush = 1'b1;
            for (int t = 0; t < 16; t++) begin
                pending[t] = 1'b0;
            end
            flushed       = flushed + pending_count;
            pending_count = 0;
        end else begin
            if (!offer_valid && issued < NUM_LOADS && pending_count < MAX_INFLIGHT &&
                $urandom_range(0, 3) != 0) begin
                build_offer();
            end
            if (offer_valid) begin
                i_ld_valid  = 1'b1;
                i_ld_func   = offer_func;
                i_ld_tag    = offer_tag;
                i_ld_base   = offer_base;
                i_ld_offset = offer_offset;
                // Stall is registered, so its value now holds at the next edge
                if (!o_stall) begin
                    pending[offer_tag]   = 1'b1;
                    pend_func[offer_tag] = offer_func;
                    pend_addr[offer_tag] = offer_addr;
                    line_issued[offer_addr[7:2]] = 1'b1;
                    pending_count = pending_count + 1;
                    issued        = issued + 1;
                    offer_valid   = 1'b0;
                end else begin
                    held_offers = held_offers + 1;
                end
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, %0d loads still in flight",
                 WATCHDOG_CYCLES, pending_count);
        abort_run();
    end

    initial begin
        int seed_ret;
        seed_ret     = $urandom(39891);
        i_rst_n      = 1'b0;
        i_flush      = 1'b0;
        i_ld_valid   = 1'b0;
        i_ld_func    = LSU_LW;
        i_ld_tag     = 4'd0;
        i_ld_base    = 16'd0;
        i_ld_offset  = 16'd0;
        i_mem_valid  = 1'b0;
        i_mem_data   = 32'd0;
        line_issued  = '0;
        offer_valid  = 1'b0;
        mem_busy     = 1'b0;
        mem_wait     = 0;
        recent_valid = 1'b0;
        pending_count = 0;
        issued       = 0;
        answered     = 0;
        flushed      = 0;
        held_offers  = 0;
        for (int t = 0; t < 16; t++) begin
            pending[t] = 1'b0;
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            mem_word[i] = $urandom;
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        while (issued < NUM_LOADS || pending_count != 0 || offer_valid) begin
            @(negedge clk);
            check_response();
            serve_memory();
            drive_loads();
        end
        // Idle tail catches late or repeated responses
        repeat (30) begin
            @(negedge clk);
            check_response();
            serve_memory();
            drive_loads();
        end

        // Flush and stall paths must both have been driven
        if (flushed == 0 || held_offers == 0) begin
            $display("Run never reached a flush or a stalled offer: %0d flushed, %0d held",
                     flushed, held_offers);
            abort_run();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: verilog/lsu_top.sv
// Load pipeline top level joining the four stages, the replay queue and the miss handler
`timescale 1ns/1ps

module lsu_top (
    input  logic                                  clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_flush,
    input  logic                                  i_ld_valid,
    input  lsu_pkg::lsu_func_e                    i_ld_func,
    input  logic [lsu_pkg::TAG_WIDTH-1:0]         i_ld_tag,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]        i_ld_base,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]        i_ld_offset,
    output logic                                  o_stall,
    output logic                                  o_resp_valid,
    output lsu_pkg::lsu_resp_t                    o_resp,
    output logic                                  o_mem_req,
    output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] o_mem_line,
    input  logic                                  i_mem_valid,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]        i_mem_data
);
    import lsu_pkg::*;
    import cache_pkg::*;

    logic                       am_valid;
    lsu_op_t                    am_op;
    logic                       dt_valid;
    lsu_op_t                    dt_op;
    logic [CTAG_WIDTH-1:0]      dt_ctag;
    logic                       dt_ctag_valid;
    logic                       dw_valid;
    lsu_op_t                    dw_op;
    logic                       dw_hit;
    logic                       dw_fill_replay;
    logic                       dw_lookup_valid;
    logic                       rq_push;
    lsu_op_t                    rq_push_op;
    logic                       rq_valid;
    lsu_op_t                    rq_op;
    logic                       mhq_alloc;
    logic [LINE_ADDR_WIDTH-1:0] mhq_alloc_line;
    logic                       mhq_busy;
    logic [LINE_ADDR_WIDTH-1:0] mhq_line;
    dc_fill_t                   fill;

    lsu_am am_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_ld_valid(i_ld_valid), .i_ld_func(i_ld_func), .i_ld_tag(i_ld_tag),
        .i_ld_base(i_ld_base), .i_ld_offset(i_ld_offset), .i_stall(o_stall),
        .i_rq_valid(rq_valid), .i_rq_op(rq_op),
        .o_valid(am_valid), .o_op(am_op)
    );

    lsu_dt dt_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_valid(am_valid), .i_op(am_op), .i_fill(fill),
        .o_valid(dt_valid), .o_op(dt_op), .o_ctag(dt_ctag), .o_ctag_valid(dt_ctag_valid)
    );

    lsu_dw dw_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_valid(dt_valid), .i_op(dt_op), .i_ctag(dt_ctag), .i_ctag_valid(dt_ctag_valid),
        .i_fill(fill),
        .o_valid(dw_valid), .o_op(dw_op), .o_hit(dw_hit),
        .o_fill_replay(dw_fill_replay), .o_mhq_lookup_valid(dw_lookup_valid)
    );

    lsu_dc dc_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_valid(dw_valid), .i_op(dw_op), .i_hit(dw_hit),
        .i_fill_replay(dw_fill_replay), .i_mhq_lookup_valid(dw_lookup_valid),
        .i_fill(fill), .i_mhq_busy(mhq_busy), .i_mhq_line(mhq_line),
        .o_resp_valid(o_resp_valid), .o_resp(o_resp),
        .o_rq_push(rq_push), .o_rq_op(rq_push_op),
        .o_mhq_alloc(mhq_alloc), .o_mhq_alloc_line(mhq_alloc_line)
    );

    lsu_replay_queue rq_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_push(rq_push), .i_op(rq_push_op), .i_busy_am(am_valid),
        .o_valid(rq_valid), .o_op(rq_op), .o_stall(o_stall)
    );

    mhq_fsm mhq_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_alloc(mhq_alloc), .i_alloc_line(mhq_alloc_line),
        .i_mem_valid(i_mem_valid), .i_mem_data(i_mem_data),
        .o_mem_req(o_mem_req), .o_mem_line(o_mem_line),
        .o_busy(mhq_busy), .o_line(mhq_line), .o_fill(fill)
    );

endmodule

// File: mhq/mhq_fsm.sv
// Single entry miss handler fetching one line from memory and filling the cache
`timescale 1ns/1ps

module mhq_fsm (
    input  logic                                  clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_alloc,
    input  logic [cache_pkg::LINE_ADDR_WIDTH-1:0] i_alloc_line,
    input  logic                                  i_mem_valid,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]        i_mem_data,
    output logic                                  o_mem_req,
    output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] o_mem_line,
    output logic                                  o_busy,
    output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] o_line,
    output cache_pkg::dc_fill_t                   o_fill
);
    import lsu_pkg::*;
    import cache_pkg::*;

    mhq_state_e                 state;
    mhq_state_e                 state_next;
    logic [LINE_ADDR_WIDTH-1:0] line_q;
    logic [DATA_WIDTH-1:0]      data_q;

    always_comb begin
        state_next = state;
        case (state)
            MHQ_IDLE: if (i_alloc) state_next = MHQ_REQ;
            MHQ_REQ:  state_next = MHQ_WAIT;
            // Memory latency varies, stay until the data pulse
            MHQ_WAIT: if (i_mem_valid) state_next = MHQ_FILL;
            default:  state_next = MHQ_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= MHQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == MHQ_IDLE && i_alloc) begin
            line_q <= i_alloc_line;
        end
        if (state == MHQ_WAIT && i_mem_valid) begin
            data_q <= i_mem_data;
        end
    end

    assign o_mem_req  = (state == MHQ_REQ);
    assign o_mem_line = line_q;
    assign o_busy     = (state != MHQ_IDLE);
    assign o_line     = line_q;

    always_comb begin
        o_fill.en   = (state == MHQ_FILL);
        o_fill.line = line_q;
        o_fill.data = data_q;
    end

endmodule

// File: lsu/lsu_replay_queue.sv
// Four entry replay FIFO that holds each head load for a fixed delay before reinjecting it
`timescale 1ns/1ps

module lsu_replay_queue (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_flush,
    input  logic             i_push,
    input  lsu_pkg::lsu_op_t i_op,
    input  logic             i_busy_am,
    output logic             o_valid,
    output lsu_pkg::lsu_op_t o_op,
    output logic             o_stall
);
    import lsu_pkg::*;

    localparam int PTR_WIDTH = $clog2(REPLAY_DEPTH);
    localparam int CNT_WIDTH = $clog2(REPLAY_DELAY + 1);

    lsu_op_t                entry_q [REPLAY_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [PTR_WIDTH:0]     count;
    logic [CNT_WIDTH-1:0]   delay;
    logic                   empty;
    logic                   new_head;

    assign empty   = (count == '0);
    assign o_stall = ~empty;
    assign o_op    = entry_q[rd_ptr];

    // Wait for a free AM slot once the delay has run out
    assign o_valid = ~empty & (delay == '0) & ~i_busy_am;

    assign new_head = (i_push & empty) | (o_valid & (i_push | (count > 1)));

    always_ff @(posedge clk) begin
        if (i_push) begin
            entry_q[wr_ptr] <= i_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            delay  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_WIDTH'(i_push);
            rd_ptr <= rd_ptr + PTR_WIDTH'(o_valid);
            count  <= count + (PTR_WIDTH + 1)'(i_push) - (PTR_WIDTH + 1)'(o_valid);
            if (new_head) begin
                delay <= CNT_WIDTH'(REPLAY_DELAY);
            end else if (delay != '0) begin
                delay <= delay - 1'b1;
            end
        end
    end

endmodule

// File: lsu/lsu_dc.sv
// Data stage reading the data array and sending each load to response, replay or miss
`timescale 1ns/1ps

module lsu_dc (
    input  logic                                  clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_flush,
    input  logic                                  i_valid,
    input  lsu_pkg::lsu_op_t                      i_op,
    input  logic                                  i_hit,
    input  logic                                  i_fill_replay,
    input  logic                                  i_mhq_lookup_valid,
    input  cache_pkg::dc_fill_t                   i_fill,
    input  logic                                  i_mhq_busy,
    input  logic [cache_pkg::LINE_ADDR_WIDTH-1:0] i_mhq_line,
    output logic                                  o_resp_valid,
    output lsu_pkg::lsu_resp_t                    o_resp,
    output logic                                  o_rq_push,
    output lsu_pkg::lsu_op_t                      o_rq_op,
    output logic                                  o_mhq_alloc,
    output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] o_mhq_alloc_line
);
    import lsu_pkg::*;
    import cache_pkg::*;

    logic [DATA_WIDTH-1:0]      data_q [1 << INDEX_WIDTH];
    logic [LINE_ADDR_WIDTH-1:0] op_line;
    logic [DATA_WIDTH-1:0]      shifted;
    logic [DATA_WIDTH-1:0]      result;
    logic                       live;
    logic                       answer;
    logic                       mhq_free;
    lsu_op_t                    replay_op;

    assign op_line = i_op.addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    assign shifted = data_q[op_line[INDEX_WIDTH-1:0]] >> {i_op.addr[OFFSET_WIDTH-1:0], 3'b000};

    always_comb begin
        case (i_op.func)
            LSU_LH:  result = {{16{shifted[15]}}, shifted[15:0]};
            LSU_HU:  result = {16'd0, shifted[15:0]};
            LSU_LB:  result = {{24{shifted[7]}}, shifted[7:0]};
            LSU_LBU: result = {24'd0, shifted[7:0]};
            default: result = shifted;
        endcase
    end

    assign live   = i_valid & ~i_flush;
    assign answer = i_hit & ~i_fill_replay;

    // The handler takes a request once idle, and its last fill cycle lets the
    // next miss in early unless that miss is the line being filled
    assign mhq_free = ~o_mhq_alloc &
                      (~i_mhq_busy | (i_fill.en & (i_mhq_line != op_line)));

    always_comb begin
        replay_op        = i_op;
        replay_op.replay = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (i_fill.en) begin
            data_q[i_fill.line[INDEX_WIDTH-1:0]] <= i_fill.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_resp_valid <= 1'b0;
            o_rq_push    <= 1'b0;
            o_mhq_alloc  <= 1'b0;
        end else begin
            o_resp_valid <= live & answer;
            o_rq_push    <= live & ~answer;
            o_mhq_alloc  <= i_mhq_lookup_valid & ~i_hit & mhq_free;
        end
    end

    always_ff @(posedge clk) begin
        o_resp.tag       <= i_op.tag;
        o_resp.data      <= result;
        o_rq_op          <= replay_op;
        o_mhq_alloc_line <= op_line;
    end

endmodule

// File: lsu/lsu_dw.sv
// Hit check stage comparing tags and catching loads that collide with a line fill
`timescale 1ns/1ps

module lsu_dw (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_flush,
    input  logic                             i_valid,
    input  lsu_pkg::lsu_op_t                 i_op,
    input  logic [cache_pkg::CTAG_WIDTH-1:0] i_ctag,
    input  logic                             i_ctag_valid,
    input  cache_pkg::dc_fill_t              i_fill,
    output logic                             o_valid,
    output lsu_pkg::lsu_op_t                 o_op,
    output logic                             o_hit,
    output logic                             o_fill_replay,
    output logic                             o_mhq_lookup_valid
);
    import lsu_pkg::*;
    import cache_pkg::*;

    logic [LINE_ADDR_WIDTH-1:0] op_line;
    logic                       index_clash;
    logic                       hit;
    logic                       fill_replay;
    logic                       lookup_valid;

    assign op_line = i_op.addr[ADDR_WIDTH-1:OFFSET_WIDTH];

    // A fill on this index evicts whatever the tag read saw
    assign index_clash = i_fill.en &
                         (i_fill.line[INDEX_WIDTH-1:0] == op_line[INDEX_WIDTH-1:0]);

    assign hit = i_ctag_valid & ~index_clash &
                 (i_ctag == op_line[LINE_ADDR_WIDTH-1 -: CTAG_WIDTH]);

    // Line is being written right now, so replay without asking the miss handler
    assign fill_replay  = i_fill.en & (i_fill.line == op_line);
    assign lookup_valid = i_valid & ~i_flush & ~fill_replay;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid            <= 1'b0;
            o_mhq_lookup_valid <= 1'b0;
        end else begin
            o_valid            <= i_valid & ~i_flush;
            o_mhq_lookup_valid <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_op          <= i_op;
        o_hit         <= hit;
        o_fill_replay <= fill_replay;
    end

endmodule

// File: lsu/lsu_dt.sv
// Tag stage holding the tag and valid arrays, read per load and written on a fill
`timescale 1ns/1ps

module lsu_dt (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_flush,
    input  logic                             i_valid,
    input  lsu_pkg::lsu_op_t                 i_op,
    input  cache_pkg::dc_fill_t              i_fill,
    output logic                             o_valid,
    output lsu_pkg::lsu_op_t                 o_op,
    output logic [cache_pkg::CTAG_WIDTH-1:0] o_ctag,
    output logic                             o_ctag_valid
);
    import lsu_pkg::*;
    import cache_pkg::*;

    localparam int LINES = 1 << INDEX_WIDTH;

    logic [CTAG_WIDTH-1:0]  tag_q [LINES];
    logic [LINES-1:0]       tag_valid_q;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [INDEX_WIDTH-1:0] fill_index;
    logic [CTAG_WIDTH-1:0]  fill_ctag;
    logic                   fill_bypass;

    assign rd_index   = i_op.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign fill_index = i_fill.line[INDEX_WIDTH-1:0];
    assign fill_ctag  = i_fill.line[LINE_ADDR_WIDTH-1 -: CTAG_WIDTH];

    // A fill on the same index lands on this edge, so pass its tag through
    assign fill_bypass = i_fill.en & (fill_index == rd_index);

    always_ff @(posedge clk) begin
        if (i_fill.en) begin
            tag_q[fill_index] <= fill_ctag;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tag_valid_q <= '0;
        end else if (i_fill.en) begin
            tag_valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid & ~i_flush;
        end
    end

    always_ff @(posedge clk) begin
        o_op         <= i_op;
        o_ctag       <= fill_bypass ? fill_ctag : tag_q[rd_index];
        o_ctag_valid <= fill_bypass | tag_valid_q[rd_index];
    end

endmodule

// File: lsu/lsu_am.sv
// Address stage picking a replayed or a new load and forming base plus offset
`timescale 1ns/1ps

module lsu_am (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_flush,
    input  logic                           i_ld_valid,
    input  lsu_pkg::lsu_func_e             i_ld_func,
    input  logic [lsu_pkg::TAG_WIDTH-1:0]  i_ld_tag,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0] i_ld_base,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0] i_ld_offset,
    input  logic                           i_stall,
    input  logic                           i_rq_valid,
    input  lsu_pkg::lsu_op_t               i_rq_op,
    output logic                           o_valid,
    output lsu_pkg::lsu_op_t               o_op
);
    import lsu_pkg::*;

    logic    ld_take;
    lsu_op_t new_op;
    lsu_op_t next_op;

    // A new load only gets in when the replay queue is empty
    assign ld_take = i_ld_valid & ~i_stall;

    always_comb begin
        new_op.func   = i_ld_func;
        new_op.tag    = i_ld_tag;
        new_op.addr   = i_ld_base + i_ld_offset;
        new_op.replay = 1'b0;
    end

    // Reinjected loads win and keep their replay flag
    assign next_op = i_rq_valid ? i_rq_op : new_op;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= ~i_flush & (i_rq_valid | ld_take);
        end
    end

    always_ff @(posedge clk) begin
        o_op <= next_op;
    end

endmodule

// File: common/cache_pkg.sv
// Cache geometry, line fill struct and miss handler states
package cache_pkg;

    // Direct mapped, 16 lines of one 32-bit word
    localparam int OFFSET_WIDTH    = 2;
    localparam int INDEX_WIDTH     = 4;
    localparam int LINE_ADDR_WIDTH = 14;
    localparam int CTAG_WIDTH      = 10;

    // Broadcast from the miss handler to DT, DW and DC
    typedef struct packed {
        logic                       en;
        logic [LINE_ADDR_WIDTH-1:0] line;
        logic [31:0]                data;
    } dc_fill_t;

    typedef enum logic [1:0] {
        MHQ_IDLE = 2'd0,
        MHQ_REQ  = 2'd1,
        MHQ_WAIT = 2'd2,
        MHQ_FILL = 2'd3
    } mhq_state_e;

endpackage

// File: common/lsu_pkg.sv
// Load op package with width opcodes, op and response structs and pipeline sizes
package lsu_pkg;

    localparam int ADDR_WIDTH   = 16;
    localparam int DATA_WIDTH   = 32;
    localparam int TAG_WIDTH    = 4;

    // Replay queue sizing
    localparam int REPLAY_DEPTH = 4;
    localparam int REPLAY_DELAY = 6;

    // AM, DT, DW and DC
    localparam int PIPE_STAGES  = 4;

    // Load width opcodes
    typedef enum logic [2:0] {
        LSU_LW  = 3'd0,
        LSU_LH  = 3'd1,
        // Halfword, zero extended
        LSU_HU  = 3'd2,
        LSU_LB  = 3'd3,
        LSU_LBU = 3'd4
    } lsu_func_e;

    // One load as it moves down the pipeline
    typedef struct packed {
        lsu_func_e              func;
        logic [TAG_WIDTH-1:0]   tag;
        logic [ADDR_WIDTH-1:0]  addr;
        // Set once the load has gone through the replay queue
        logic                   replay;
    } lsu_op_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]   tag;
        logic [DATA_WIDTH-1:0]  data;
    } lsu_resp_t;

endpackage
